// ==== hdl/cpc_loader_pkg.sv ====
/*
 * CPC loader package
 * Widths, boot and expansion page numbers, download indices,
 * and the memory request and download beat structs
 */
package cpc_loader_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////

	localparam int MEM_AW   = 23;
	localparam int DATA_W   = 8;
	localparam int PAGE_W   = 9;
	localparam int BLOCK_AW = 14;
	localparam int DL_AW    = 25;
	localparam int BANK_W   = 2;
	localparam int INDEX_W  = 8;
	localparam int EXT_W    = 16;

	//////////////////////////////
	// Page numbers
	//////////////////////////////

	// Boot image pages, top bit selects the high ROM half
	localparam logic [PAGE_W-1:0] PAGE_OS     = 9'h000;
	localparam logic [PAGE_W-1:0] PAGE_BASIC  = 9'h100;
	localparam logic [PAGE_W-1:0] PAGE_AMSDOS = 9'h107;
	localparam logic [PAGE_W-1:0] PAGE_MF2    = 9'h0FF;

	// Spare page for an extension that is not hex
	localparam logic [PAGE_W-1:0] PAGE_BAD_EXT = 9'h1EE;

	// Second page of a combined "Z0" image
	localparam logic [PAGE_W-1:0] PAGE_COMBO_NEXT = 9'h1FF;

	// Download indices
	localparam logic [INDEX_W-1:0] TAPE_INDEX = 8'd4;
	// Compared against the low five index bits
	localparam logic [4:0] ROM_INDEX_LIMIT = 5'd4;

	//////////////////////////////
	// Structs
	//////////////////////////////

	// One request on the shared memory port
	typedef struct packed {
		logic [MEM_AW-1:0] addr;
		logic [BANK_W-1:0] bank;
		logic              we;
		logic [DATA_W-1:0] wdata;
	} mem_cmd_t;

	// One beat from the host download
	typedef struct packed {
		logic [INDEX_W-1:0] index;
		logic [DL_AW-1:0]   addr;
		logic [DATA_W-1:0]  data;
		logic [EXT_W-1:0]   ext;
	} dl_beat_t;

endpackage

// ==== hdl/rom_loader.sv ====
/*
 * ROM loader
 * Places 16 KB blocks of boot and expansion ROM images at their memory
 * pages and banks, and keeps the map of loaded high ROM pages
 */
`timescale 1ns/1ps

module rom_loader (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  cpc_loader_pkg::dl_beat_t dl,
	input  logic                     dl_active,
	input  logic                     dl_wr,
	output logic                     busy,
	output logic                     req,
	output cpc_loader_pkg::mem_cmd_t cmd,
	input  logic                     ack,
	output logic [255:0]             rom_map,
	output logic                     cpu_reset
);

	logic                              rom_download;
	logic                              dl_active_q;
	logic [cpc_loader_pkg::PAGE_W-1:0] page;
	logic                              combo;
	logic                              dual;

	// Beat decode
	logic                              beat_ok;
	logic                              beat_bank;
	logic                              beat_dual;
	logic [cpc_loader_pkg::PAGE_W-1:0] beat_page;
	logic [7:0]                        page_sum;

	// Extension decode
	logic [4:0]                        ext_hi;
	logic [4:0]                        ext_lo;
	logic [cpc_loader_pkg::PAGE_W-1:0] ext_page;
	logic                              ext_combo;

	// Valid flag and nibble of one ASCII hex digit
	function automatic logic [4:0] hex_digit(input logic [7:0] c);
		logic [4:0] r;
		r = 5'd0;
		if (c >= "0" && c <= "9") r = {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F") r = {1'b1, c[3:0] + 4'd9};
		return r;
	endfunction

	assign rom_download = dl_active && (dl.index[4:0] < cpc_loader_pkg::ROM_INDEX_LIMIT);
	assign cpu_reset    = rom_download;

	always_comb begin
		page_sum  = page[7:0] + dl.addr[21:14];
		beat_ok   = 1'b1;
		beat_bank = &dl.index[7:6];
		beat_page = {page[8], page_sum};
		if (dl.index == 8'd0) begin
			// Blocks 4-7 are the 664 image in bank 1
			beat_bank = dl.addr[16];
			case (dl.addr[24:14])
				11'd0, 11'd4: beat_page = cpc_loader_pkg::PAGE_OS;
				11'd1, 11'd5: beat_page = cpc_loader_pkg::PAGE_BASIC;
				11'd2, 11'd6: beat_page = cpc_loader_pkg::PAGE_AMSDOS;
				11'd3, 11'd7: beat_page = cpc_loader_pkg::PAGE_MF2;
				default:      beat_ok = 1'b0;
			endcase
		end
		// Expansion ROMs go to both banks
		beat_dual = (dl.index[7:6] == 2'b01 || |dl.index[5:0]) && !beat_bank;
	end

	always_comb begin
		ext_hi    = hex_digit(dl.ext[15:8]);
		ext_lo    = hex_digit(dl.ext[7:0]);
		ext_combo = 1'b0;
		ext_page  = cpc_loader_pkg::PAGE_BAD_EXT;
		if (ext_hi[4]) ext_page[7:4] = ext_hi[3:0];
		if (ext_lo[4]) ext_page[3:0] = ext_lo[3:0];
		if (dl.ext == "ZZ") ext_page = '0;
		if (dl.ext == "Z0") begin
			ext_page  = '0;
			ext_combo = 1'b1;
		end
	end

	//////////////////////////////
	// Control
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			busy        <= 1'b0;
			req         <= 1'b0;
			dual        <= 1'b0;
			rom_map     <= '0;
			page        <= cpc_loader_pkg::PAGE_BAD_EXT;
			combo       <= 1'b0;
			dl_active_q <= 1'b0;
		end else begin
			dl_active_q <= dl_active;
			if (rom_download && dl_wr && beat_ok) begin
				busy <= 1'b1;
				req  <= 1'b1;
				dual <= beat_dual;
			end
			if (req && ack) begin
				if (dual) begin
					dual <= 1'b0;
				end else begin
					req  <= 1'b0;
					busy <= 1'b0;
					if (cmd.addr[cpc_loader_pkg::MEM_AW-1])
						rom_map[cmd.addr[cpc_loader_pkg::BLOCK_AW +: 8]] <= 1'b1;
					// Last byte of the first "Z0" page
					if (combo && &cmd.addr[cpc_loader_pkg::BLOCK_AW-1:0]) begin
						combo <= 1'b0;
						page  <= cpc_loader_pkg::PAGE_COMBO_NEXT;
					end
				end
			end
			// New expansion download starts
			if (rom_download && !dl_active_q && dl.index != 8'd0) begin
				page  <= ext_page;
				combo <= ext_combo;
			end
		end
	end

	// Write command
	always_ff @(posedge clk_sys) begin
		if (rom_download && dl_wr && beat_ok) begin
			cmd.addr  <= {beat_page, dl.addr[cpc_loader_pkg::BLOCK_AW-1:0]};
			cmd.bank  <= {1'b0, beat_bank};
			cmd.we    <= 1'b1;
			cmd.wdata <= dl.data;
		end else if (req && ack && dual) begin
			cmd.bank <= 2'b01;
		end
	end

endmodule

// ==== hdl/tape_buffer.sv ====
/*
 * Tape buffer
 * Writes a downloaded tape image to memory and plays it back
 * one byte per request toggle
 */
`timescale 1ns/1ps

module tape_buffer (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  cpc_loader_pkg::dl_beat_t            dl,
	input  logic                                dl_active,
	input  logic                                dl_wr,
	output logic                                busy,
	output logic                                req,
	output cpc_loader_pkg::mem_cmd_t            cmd,
	input  logic                                ack,
	input  logic [cpc_loader_pkg::DATA_W-1:0]   rdata,
	input  logic                                tape_restart,
	input  logic                                tape_req,
	output logic                                tape_ack,
	output logic                                tape_ready,
	output logic [cpc_loader_pkg::DATA_W-1:0]   tape_dout
);

	logic                              tape_download;
	logic                              wr_pend;
	logic                              rd_pend;
	logic [cpc_loader_pkg::DATA_W-1:0] wr_data;
	logic [cpc_loader_pkg::MEM_AW-1:0] last_addr;
	logic [cpc_loader_pkg::MEM_AW-1:0] play_addr;

	assign tape_download = dl_active && (dl.index == cpc_loader_pkg::TAPE_INDEX);
	// Player flipped its request and no answer yet
	assign rd_pend       = tape_req ^ tape_ack;
	assign tape_ready    = (last_addr != '0) && (play_addr <= last_addr);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			busy      <= 1'b0;
			wr_pend   <= 1'b0;
			req       <= 1'b0;
			tape_ack  <= 1'b0;
			last_addr <= '0;
			play_addr <= '0;
		end else begin
			if (tape_download && dl_wr) begin
				wr_pend   <= 1'b1;
				busy      <= 1'b1;
				last_addr <= dl.addr[cpc_loader_pkg::MEM_AW-1:0];
			end
			if (!req) begin
				if (wr_pend) begin
					req     <= 1'b1;
					wr_pend <= 1'b0;
				end else if (rd_pend && !tape_download) begin
					req <= 1'b1;
				end
			end else if (ack) begin
				req <= 1'b0;
				if (cmd.we) begin
					busy <= 1'b0;
				end else begin
					tape_ack <= ~tape_ack;
					// Hold on the last byte at the end of the image
					if (play_addr < last_addr) play_addr <= play_addr + 1'b1;
				end
			end
			if (tape_download) play_addr <= '0;
			if (tape_restart) begin
				play_addr <= '0;
				last_addr <= '0;
			end
		end
	end

	// Command and read data
	always_ff @(posedge clk_sys) begin
		if (tape_download && dl_wr) wr_data <= dl.data;
		if (!req) begin
			cmd.addr  <= wr_pend ? last_addr : play_addr;
			cmd.bank  <= 2'b00;
			cmd.we    <= wr_pend;
			cmd.wdata <= wr_data;
		end
		if (req && ack && !cmd.we) tape_dout <= rdata;
	end

endmodule

// ==== hdl/mem_arbiter.sv ====
/*
 * Memory arbiter
 * Fixed priority access to the shared memory port for the ROM loader,
 * the tape buffer and the CPU
 */
`timescale 1ns/1ps

module mem_arbiter (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     cpu_block,
	input  logic                     loader_req,
	input  cpc_loader_pkg::mem_cmd_t loader_cmd,
	output logic                     loader_ack,
	input  logic                     tape_req,
	input  cpc_loader_pkg::mem_cmd_t tape_cmd,
	output logic                     tape_ack,
	input  logic                     cpu_req,
	input  cpc_loader_pkg::mem_cmd_t cpu_cmd,
	output logic                     cpu_ack,
	output logic                     mem_valid,
	output cpc_loader_pkg::mem_cmd_t mem_cmd,
	input  logic                     mem_ack
);

	// One-hot owner, bit 0 loader, bit 1 tape, bit 2 CPU
	logic [2:0] grant;
	logic [2:0] pick;
	logic       done;

	assign done = mem_valid && mem_ack;

	// Priority pick
	always_comb begin
		pick = 3'b000;
		if (loader_req) pick = 3'b001;
		else if (tape_req) pick = 3'b010;
		else if (cpu_req && !cpu_block) pick = 3'b100;
	end

	//////////////////////////////
	// Ownership
	//////////////////////////////

	// Owner and command hold until the memory acknowledges
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mem_valid <= 1'b0;
			grant     <= 3'b000;
		end else if (mem_valid) begin
			if (mem_ack) begin
				mem_valid <= 1'b0;
				grant     <= 3'b000;
			end
		end else if (|pick) begin
			mem_valid <= 1'b1;
			grant     <= pick;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!mem_valid) begin
			case (pick)
				3'b001:  mem_cmd <= loader_cmd;
				3'b010:  mem_cmd <= tape_cmd;
				3'b100:  mem_cmd <= cpu_cmd;
				default: mem_cmd <= mem_cmd;
			endcase
		end
	end

	// Acknowledge goes back to the owner only
	assign loader_ack = done && grant[0];
	assign tape_ack   = done && grant[1];
	assign cpu_ack    = done && grant[2];

endmodule

// ==== hdl/cpc_loader_top.sv ====
/*
 * CPC loader top level
 * ROM loader, tape buffer and CPU port sharing one memory port
 */
`timescale 1ns/1ps

module cpc_loader_top (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  cpc_loader_pkg::dl_beat_t          dl,
	input  logic                              dl_active,
	input  logic                              dl_wr,
	output logic                              dl_wait,
	input  logic                              cpu_valid,
	input  cpc_loader_pkg::mem_cmd_t          cpu_cmd,
	output logic                              cpu_ack,
	output logic [cpc_loader_pkg::DATA_W-1:0] cpu_rdata,
	output logic                              cpu_reset,
	input  logic                              model,
	input  logic                              tape_restart,
	input  logic                              tape_req,
	output logic                              tape_ack,
	output logic                              tape_ready,
	output logic [cpc_loader_pkg::DATA_W-1:0] tape_dout,
	output logic [255:0]                      rom_map,
	output logic                              mem_valid,
	output cpc_loader_pkg::mem_cmd_t          mem_cmd,
	input  logic                              mem_ack,
	input  logic [cpc_loader_pkg::DATA_W-1:0] mem_rdata
);

	logic                     loader_busy;
	logic                     loader_req;
	logic                     loader_ack;
	cpc_loader_pkg::mem_cmd_t loader_cmd;
	logic                     tbuf_busy;
	logic                     tbuf_req;
	logic                     tbuf_ack;
	cpc_loader_pkg::mem_cmd_t tbuf_cmd;
	cpc_loader_pkg::mem_cmd_t cpu_cmd_bank;

	assign dl_wait   = loader_busy | tbuf_busy;
	assign cpu_rdata = mem_rdata;

	// CPU bank follows the selected model
	always_comb begin
		cpu_cmd_bank      = cpu_cmd;
		cpu_cmd_bank.bank = {1'b0, model};
	end

	rom_loader i_rom_loader (
		.clk_sys(clk_sys), .reset(reset), .dl(dl), .dl_active(dl_active),
		.dl_wr(dl_wr), .busy(loader_busy), .req(loader_req), .cmd(loader_cmd),
		.ack(loader_ack), .rom_map(rom_map), .cpu_reset(cpu_reset)
	);

	tape_buffer i_tape_buffer (
		.clk_sys(clk_sys), .reset(reset), .dl(dl), .dl_active(dl_active),
		.dl_wr(dl_wr), .busy(tbuf_busy), .req(tbuf_req), .cmd(tbuf_cmd),
		.ack(tbuf_ack), .rdata(mem_rdata), .tape_restart(tape_restart),
		.tape_req(tape_req), .tape_ack(tape_ack), .tape_ready(tape_ready),
		.tape_dout(tape_dout)
	);

	mem_arbiter i_mem_arbiter (
		.clk_sys(clk_sys), .reset(reset), .cpu_block(cpu_reset),
		.loader_req(loader_req), .loader_cmd(loader_cmd), .loader_ack(loader_ack),
		.tape_req(tbuf_req), .tape_cmd(tbuf_cmd), .tape_ack(tbuf_ack),
		.cpu_req(cpu_valid), .cpu_cmd(cpu_cmd_bank), .cpu_ack(cpu_ack),
		.mem_valid(mem_valid), .mem_cmd(mem_cmd), .mem_ack(mem_ack)
	);

endmodule

// ==== sim/tb_cpc_loader.sv ====
/*
 * Testbench for the CPC loader top level
 * Memory model with random acknowledge latency, reference model of the
 * ROM loader, tape buffer and CPU port, and self-checking tests
 */
`timescale 1ns/1ps

module tb_cpc_loader;

	localparam int DRIVE_DELAY = 1;
	// Beats per boot block
	localparam int BOOT_BEATS  = 6;
	localparam int EXP_LOADS   = 6;
	localparam int BAD_LOADS   = 4;
	localparam int LOAD_BEATS  = 5;
	localparam int TAPE_LEN    = 24;
	localparam int TAPE_READS  = TAPE_LEN + 4;
	localparam int CPU_OPS     = 40;
	localparam int TOTAL_BEATS = 10 * BOOT_BEATS + (EXP_LOADS + BAD_LOADS) * LOAD_BEATS
		+ TAPE_LEN + TAPE_READS + CPU_OPS + 1;
	localparam int CYCLE_LIMIT = TOTAL_BEATS * 12 + 2000;
	localparam logic [22:0] BLOCKED_ADDR = 23'h300040;

	logic                     clk_sys = 1'b0;
	logic                     reset;
	cpc_loader_pkg::dl_beat_t dl;
	logic                     dl_active;
	logic                     dl_wr;
	logic                     dl_wait;
	logic                     cpu_valid;
	cpc_loader_pkg::mem_cmd_t cpu_cmd;
	logic                     cpu_ack;
	logic [7:0]               cpu_rdata;
	logic                     cpu_reset;
	logic                     model;
	logic                     tape_restart;
	logic                     tape_req;
	logic                     tape_ack;
	logic                     tape_ready;
	logic [7:0]               tape_dout;
	logic [255:0]             rom_map;
	logic                     mem_valid;
	cpc_loader_pkg::mem_cmd_t mem_cmd;
	logic                     mem_ack;
	logic [7:0]               mem_rdata;

	// Memory contents and the expected contents
	logic [7:0]   mem_bank0 [int];
	logic [7:0]   mem_bank1 [int];
	logic [7:0]   ref_bank0 [int];
	logic [7:0]   ref_bank1 [int];
	logic [255:0] exp_map = '0;
	logic [7:0]   tape_img [TAPE_LEN];
	logic         rom_dl = 1'b0;
	int           mem_writes = 0;
	int           exp_writes = 0;
	int           checks = 0;
	int           errors = 0;
	int           cycles = 0;
	int           wait_cnt = 0;
	string        bad_chars = "GKX@#gq";

	cpc_loader_top i_cpc_loader_top (
		.clk_sys(clk_sys), .reset(reset), .dl(dl), .dl_active(dl_active), .dl_wr(dl_wr),
		.dl_wait(dl_wait), .cpu_valid(cpu_valid), .cpu_cmd(cpu_cmd), .cpu_ack(cpu_ack),
		.cpu_rdata(cpu_rdata), .cpu_reset(cpu_reset), .model(model),
		.tape_restart(tape_restart), .tape_req(tape_req), .tape_ack(tape_ack),
		.tape_ready(tape_ready), .tape_dout(tape_dout), .rom_map(rom_map),
		.mem_valid(mem_valid), .mem_cmd(mem_cmd), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
	);

	always #50 clk_sys = ~clk_sys;

	//////////////////////////////
	// Memory model
	//////////////////////////////

	// Fill pattern for unwritten bytes from the whole address
	function automatic logic [7:0] fill_byte(input logic bank, input logic [22:0] addr);
		return addr[7:0] ^ addr[15:8] ^ {1'b0, addr[22:16]} ^ {7'd0, bank};
	endfunction

	function automatic logic [7:0] mem_read(input logic bank, input logic [22:0] addr);
		if (bank && mem_bank1.exists(int'(addr))) return mem_bank1[int'(addr)];
		if (!bank && mem_bank0.exists(int'(addr))) return mem_bank0[int'(addr)];
		return fill_byte(bank, addr);
	endfunction

	initial begin
		mem_ack   = 1'b0;
		mem_rdata = '0;
		forever begin
			@(posedge clk_sys);
			#DRIVE_DELAY;
			mem_ack = 1'b0;
			if (mem_valid) begin
				// New request gets 1 to 5 cycles of latency
				if (wait_cnt == 0) wait_cnt = $urandom_range(5, 1);
				wait_cnt = wait_cnt - 1;
				if (wait_cnt == 0) begin
					if (mem_cmd.we && mem_cmd.bank[0]) begin
						mem_bank1[int'(mem_cmd.addr)] = mem_cmd.wdata;
					end else if (mem_cmd.we) begin
						mem_bank0[int'(mem_cmd.addr)] = mem_cmd.wdata;
					end else begin
						mem_rdata = mem_read(mem_cmd.bank[0], mem_cmd.addr);
					end
					if (mem_cmd.we) mem_writes++;
					mem_ack = 1'b1;
				end
			end
		end
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic logic [7:0] ref_read(input logic bank, input logic [22:0] addr);
		if (bank && ref_bank1.exists(int'(addr))) return ref_bank1[int'(addr)];
		if (!bank && ref_bank0.exists(int'(addr))) return ref_bank0[int'(addr)];
		return fill_byte(bank, addr);
	endfunction

	task automatic ref_write(input logic bank, input logic [22:0] addr, input logic [7:0] d);
		if (bank) ref_bank1[int'(addr)] = d;
		else ref_bank0[int'(addr)] = d;
		exp_writes++;
	endtask

	// One ROM byte in the expected memory and map
	task automatic model_rom(input logic [8:0] page, input logic [13:0] off,
			input logic [7:0] d, input logic bank1, input logic both);
		if (both || !bank1) ref_write(1'b0, {page, off}, d);
		if (both || bank1) ref_write(1'b1, {page, off}, d);
		if (page[8]) exp_map[page[7:0]] = 1'b1;
	endtask

	function automatic logic [7:0] hex_char(input logic [3:0] n);
		if (n < 4'd10) return 8'h30 + 8'(n);
		return 8'h41 + 8'(n) - 8'd10;
	endfunction

	//////////////////////////////
	// Checks
	//////////////////////////////

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[ERROR] %0t %s expected %0h got %0h", $time, name, exp, got);
		end
	endtask

	task automatic check_map();
		checks++;
		assert (rom_map === exp_map) else begin
			errors++;
			$display("[ERROR] %0t rom_map expected %h got %h", $time, exp_map, rom_map);
		end
	endtask

	task automatic compare_memory();
		check_value("memory write count", exp_writes, mem_writes);
		check_value("bank 0 entries", ref_bank0.num(), mem_bank0.num());
		check_value("bank 1 entries", ref_bank1.num(), mem_bank1.num());
		foreach (ref_bank0[a])
			check_value($sformatf("bank 0 byte %0h", a), ref_bank0[a], mem_read(1'b0, 23'(a)));
		foreach (ref_bank1[a])
			check_value($sformatf("bank 1 byte %0h", a), ref_bank1[a], mem_read(1'b1, 23'(a)));
	endtask

	task automatic report_test(input int num, input string name, input int err_start);
		$display("Test %0d %s finished with %0d errors", num, name, errors - err_start);
	endtask

	// The CPU must stay off the port while a ROM download runs
	always @(negedge clk_sys) begin
		if (!reset) begin
			assert (cpu_reset === (dl_active && rom_dl)) else begin
				errors++;
				$display("[ERROR] %0t cpu_reset expected %0b got %0b", $time,
					dl_active && rom_dl, cpu_reset);
			end
			assert (!(cpu_ack && dl_active && rom_dl)) else begin
				errors++;
				$display("[ERROR] %0t CPU access acknowledged during a ROM download", $time);
			end
		end
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Run stopped, tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("*** FAILED ***");
			$finish;
		end
	end

	//////////////////////////////
	// Drivers
	//////////////////////////////

	task automatic next_cycle();
		@(posedge clk_sys);
		#DRIVE_DELAY;
	endtask

	task automatic download_start(input logic [7:0] idx, input logic [15:0] ext);
		rom_dl    = (idx[4:0] < cpc_loader_pkg::ROM_INDEX_LIMIT);
		dl.index  = idx;
		dl.ext    = ext;
		dl.addr   = '0;
		dl.data   = '0;
		dl_active = 1'b1;
		next_cycle();
	endtask

	task automatic download_finish();
		dl_active = 1'b0;
		next_cycle();
		next_cycle();
	endtask

	// One beat, then hold off while the DUT writes it
	task automatic send_beat(input logic [24:0] addr, input logic [7:0] d);
		dl.addr = addr;
		dl.data = d;
		dl_wr   = 1'b1;
		next_cycle();
		dl_wr = 1'b0;
		while (dl_wait) next_cycle();
	endtask

	// Expansion beats in the first two blocks of both banks
	task automatic load_rom_beats(input logic [8:0] base);
		int         blk;
		logic [13:0] off;
		logic [7:0]  d;
		logic [8:0]  page;
		for (int i = 0; i < LOAD_BEATS; i++) begin
			blk  = $urandom_range(1, 0);
			off  = 14'($urandom_range(16383, 0));
			d    = 8'($urandom_range(255, 0));
			page = {base[8], base[7:0] + 8'(blk)};
			model_rom(page, off, d, 1'b0, 1'b1);
			send_beat((25'(blk) << 14) | 25'(off), d);
		end
	endtask

	task automatic wait_cpu_ack(output logic [7:0] rd);
		@(negedge clk_sys);
		while (!cpu_ack) @(negedge clk_sys);
		rd = cpu_rdata;
		next_cycle();
		cpu_valid = 1'b0;
	endtask

	task automatic cpu_access(input logic we, input logic bank, input logic [22:0] addr,
			input logic [7:0] wdata, output logic [7:0] rd);
		model         = bank;
		cpu_cmd.addr  = addr;
		cpu_cmd.bank  = 2'b00;
		cpu_cmd.we    = we;
		cpu_cmd.wdata = wdata;
		cpu_valid     = 1'b1;
		wait_cpu_ack(rd);
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	initial begin
		int          err_start;
		logic [13:0] off;
		logic [7:0]  d;
		logic [7:0]  v;
		logic [7:0]  rd;
		logic [8:0]  page;
		logic [22:0] addr;
		logic        bank;
		logic        we;
		void'($urandom(32'h8109));
		reset        = 1'b1;
		dl           = '0;
		dl_active    = 1'b0;
		dl_wr        = 1'b0;
		cpu_valid    = 1'b0;
		cpu_cmd      = '0;
		model        = 1'b0;
		tape_restart = 1'b0;
		tape_req     = 1'b0;
		repeat (4) next_cycle();
		reset = 1'b0;

		// Boot image with two dropped blocks
		err_start = errors;
		check_value("dl_wait", 0, dl_wait);
		check_value("mem_valid", 0, mem_valid);
		check_value("cpu_ack", 0, cpu_ack);
		check_value("tape_ack", 0, tape_ack);
		check_value("tape_ready", 0, tape_ready);
		check_map();
		download_start(8'd0, 16'h0000);
		for (int blk = 0; blk < 10; blk++) begin
			for (int n = 0; n < BOOT_BEATS; n++) begin
				off = 14'($urandom_range(16383, 0));
				d   = 8'($urandom_range(255, 0));
				if (blk < 8) begin
					case (blk % 4)
						0:       page = cpc_loader_pkg::PAGE_OS;
						1:       page = cpc_loader_pkg::PAGE_BASIC;
						2:       page = cpc_loader_pkg::PAGE_AMSDOS;
						default: page = cpc_loader_pkg::PAGE_MF2;
					endcase
					model_rom(page, off, d, blk >= 4, 1'b0);
				end
				send_beat((25'(blk) << 14) | 25'(off), d);
			end
		end
		download_finish();
		compare_memory();
		check_map();
		report_test(1, "boot image", err_start);

		// Hex extensions and a CPU read held off by the first download
		err_start = errors;
		for (int n = 0; n < EXP_LOADS; n++) begin
			v = 8'($urandom_range(255, 0));
			download_start(8'd3, {hex_char(v[7:4]), hex_char(v[3:0])});
			if (n == 0) begin
				model        = 1'b0;
				cpu_cmd      = '0;
				cpu_cmd.addr = BLOCKED_ADDR;
				cpu_valid    = 1'b1;
			end
			load_rom_beats(9'h100 + 9'(v));
			if (n == 0) begin
				dl_active = 1'b0;
				wait_cpu_ack(rd);
				check_value("cpu_rdata", ref_read(1'b0, BLOCKED_ADDR), rd);
			end
			download_finish();
		end
		compare_memory();
		check_map();
		report_test(2, "expansion ROMs", err_start);

		// Extensions that are not hex, then ZZ
		err_start = errors;
		for (int n = 0; n < BAD_LOADS; n++) begin
			if (n == BAD_LOADS - 1) begin
				download_start(8'd3, "ZZ");
				load_rom_beats(9'h000);
			end else begin
				download_start(8'd3, {bad_chars[$urandom_range(6, 0)],
					bad_chars[$urandom_range(6, 0)]});
				load_rom_beats(cpc_loader_pkg::PAGE_BAD_EXT);
			end
			download_finish();
		end
		compare_memory();
		check_map();
		report_test(3, "odd extensions", err_start);

		// Tape image with playback past the end and a restart
		err_start = errors;
		download_start(cpc_loader_pkg::TAPE_INDEX, 16'h0000);
		for (int i = 0; i < TAPE_LEN; i++) begin
			d           = 8'($urandom_range(255, 0));
			tape_img[i] = d;
			ref_write(1'b0, 23'(i), d);
			send_beat(25'(i), d);
		end
		download_finish();
		check_value("tape_ready", 1, tape_ready);
		for (int i = 0; i < TAPE_READS; i++) begin
			tape_req = ~tape_req;
			@(negedge clk_sys);
			while (tape_ack != tape_req) @(negedge clk_sys);
			check_value("tape_dout", tape_img[(i < TAPE_LEN) ? i : TAPE_LEN - 1], tape_dout);
			next_cycle();
		end
		check_value("tape_ready", 1, tape_ready);
		tape_restart = 1'b1;
		next_cycle();
		tape_restart = 1'b0;
		check_value("tape_ready", 0, tape_ready);
		compare_memory();
		report_test(4, "tape buffer", err_start);

		// CPU reads and writes in a small window
		err_start = errors;
		for (int n = 0; n < CPU_OPS; n++) begin
			addr = 23'h300000 | 23'($urandom_range(31, 0));
			bank = 1'($urandom_range(1, 0));
			we   = 1'($urandom_range(1, 0));
			d    = 8'($urandom_range(255, 0));
			if (we) begin
				ref_write(bank, addr, d);
				cpu_access(1'b1, bank, addr, d, rd);
			end else begin
				cpu_access(1'b0, bank, addr, 8'h00, rd);
				check_value("cpu_rdata", ref_read(bank, addr), rd);
			end
		end
		compare_memory();
		report_test(5, "CPU port", err_start);

		$display("Checks run %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== cpc_loader_top.f ====
hdl/cpc_loader_pkg.sv
hdl/rom_loader.sv
hdl/tape_buffer.sv
hdl/mem_arbiter.sv
hdl/cpc_loader_top.sv
sim/tb_cpc_loader.sv

// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_cpc_loader
FILELIST   = cpc_loader_top.f
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
